// File: source/bpu_pkg.sv
package bpu_pkg;

    localparam int XLEN = 32;
    localparam int ADDR_LSB = 2;   // instructions are word aligned

    typedef logic [XLEN-1:0] addr_t;
    typedef logic [31:0] inst_t;
    typedef logic [6:0] opcode_t;
    typedef logic [4:0] reg_t;

    // 2-bit saturating counter, msb gives the direction
    typedef enum logic [1:0] {
        strong_nt = 2'b00,
        weak_nt   = 2'b01,
        weak_t    = 2'b10,
        strong_t  = 2'b11
    } ctr_state_t;

    // RV32I control transfer opcodes
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_JALR   = 7'b1100111;

    // link registers, a jalr through these is a return
    localparam reg_t REG_RA = 5'd1;
    localparam reg_t REG_T0 = 5'd5;

endpackage

// File: source/bpu_update_if.sv
`timescale 1ns/1ps

interface bpu_update_if;

    logic               upd_valid;    // resolved control instr from execute
    logic               upd_taken;
    bpu_pkg::addr_t     upd_pc;
    bpu_pkg::addr_t     upd_target;
    logic               pop_ret;      // return resolved, stall already applied
    logic               push_valid;   // call seen in decode, stall already applied
    bpu_pkg::addr_t     push_addr;

    modport source (output upd_valid, upd_taken, upd_pc, upd_target,
                    output pop_ret, push_valid, push_addr);
    modport dir_sink (input upd_valid, upd_taken, upd_pc);
    modport btb_sink (input upd_valid, upd_taken, upd_pc, upd_target);
    modport ras_sink (input pop_ret, push_valid, push_addr);

endinterface

// File: source/inst_classifier.sv
`timescale 1ns/1ps

module inst_classifier (
    input  bpu_pkg::addr_t  if_pc_i,
    input  bpu_pkg::inst_t  if_inst_i,
    input  logic            ex_valid_i,
    input  logic            ex_taken_i,
    input  logic            ex_stall_i,
    input  bpu_pkg::addr_t  ex_pc_i,
    input  bpu_pkg::addr_t  ex_target_i,
    input  bpu_pkg::addr_t  id_push_addr_i,
    input  bpu_pkg::inst_t  ex_inst_i,
    input  logic            id_push_valid_i,
    output logic            is_branch_o,
    output logic            is_jal_o,
    output logic            is_jalr_o,
    output logic            is_ret_o,
    output bpu_pkg::addr_t  static_target_o,
    bpu_update_if.source    upd
);

    bpu_pkg::opcode_t if_op;
    bpu_pkg::reg_t    if_rs1;
    bpu_pkg::addr_t   b_imm;
    bpu_pkg::addr_t   j_imm;
    logic             if_jalr;
    logic             ex_is_ret;

    assign if_op   = if_inst_i[6:0];
    assign if_rs1  = if_inst_i[19:15];
    assign if_jalr = (if_op == bpu_pkg::OPCODE_JALR);

    // ret: jalr x0, 0(ra|t0)
    assign is_ret_o    = if_jalr && (if_inst_i[11:7] == 5'd0) && (if_inst_i[31:20] == 12'd0)
                         && (if_rs1 == bpu_pkg::REG_RA || if_rs1 == bpu_pkg::REG_T0);
    assign is_branch_o = (if_op == bpu_pkg::OPCODE_BRANCH);
    assign is_jal_o    = (if_op == bpu_pkg::OPCODE_JAL);
    assign is_jalr_o   = if_jalr && !is_ret_o;   // indirect jumps other than returns

    assign b_imm = {{20{if_inst_i[31]}}, if_inst_i[7], if_inst_i[30:25], if_inst_i[11:8], 1'b0};
    assign j_imm = {{12{if_inst_i[31]}}, if_inst_i[19:12], if_inst_i[20], if_inst_i[30:21], 1'b0};
    assign static_target_o = if_pc_i + (is_jal_o ? j_imm : b_imm);

    // execute side only checks rs1, any link register jalr pops
    assign ex_is_ret = (ex_inst_i[6:0] == bpu_pkg::OPCODE_JALR)
                       && (ex_inst_i[19:15] == bpu_pkg::REG_RA
                           || ex_inst_i[19:15] == bpu_pkg::REG_T0);

    assign upd.upd_valid  = ex_valid_i;
    assign upd.upd_taken  = ex_taken_i;
    assign upd.upd_pc     = ex_pc_i;
    assign upd.upd_target = ex_target_i;
    assign upd.pop_ret    = ex_valid_i && ex_taken_i && ex_is_ret && !ex_stall_i;
    assign upd.push_valid = id_push_valid_i && !ex_stall_i;
    assign upd.push_addr  = id_push_addr_i;

endmodule

// File: source/direction_table.sv
`timescale 1ns/1ps

module direction_table #(
    parameter int DIR_ENTRIES = 64
) (
    input  logic            clk,
    input  logic            rst,
    input  bpu_pkg::addr_t  lookup_pc_i,
    output logic            dir_taken_o,
    bpu_update_if.dir_sink  upd
);

    localparam int IDX_W = (DIR_ENTRIES > 1) ? $clog2(DIR_ENTRIES) : 1;

    typedef logic [IDX_W-1:0] idx_t;

    bpu_pkg::ctr_state_t ctr_q [DIR_ENTRIES];
    idx_t                rd_idx;
    idx_t                wr_idx;
    bpu_pkg::ctr_state_t rd_state;

    // one step toward the resolved direction, saturating at both ends
    function automatic bpu_pkg::ctr_state_t step(input bpu_pkg::ctr_state_t s,
                                                 input logic taken);
        bpu_pkg::ctr_state_t n;
        case (s)
            bpu_pkg::strong_nt: n = taken ? bpu_pkg::weak_nt  : bpu_pkg::strong_nt;
            bpu_pkg::weak_nt:   n = taken ? bpu_pkg::weak_t   : bpu_pkg::strong_nt;
            bpu_pkg::weak_t:    n = taken ? bpu_pkg::strong_t : bpu_pkg::weak_nt;
            bpu_pkg::strong_t:  n = taken ? bpu_pkg::strong_t : bpu_pkg::weak_t;
            default:            n = bpu_pkg::weak_nt;
        endcase
        return n;
    endfunction

    assign rd_idx = lookup_pc_i[bpu_pkg::ADDR_LSB +: IDX_W];
    assign wr_idx = upd.upd_pc[bpu_pkg::ADDR_LSB +: IDX_W];

    assign rd_state    = ctr_q[rd_idx];
    assign dir_taken_o = (rd_state == bpu_pkg::weak_t) || (rd_state == bpu_pkg::strong_t);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DIR_ENTRIES; i++) begin
                ctr_q[i] <= bpu_pkg::weak_nt;
            end
        end else if (upd.upd_valid) begin
            ctr_q[wr_idx] <= step(ctr_q[wr_idx], upd.upd_taken);
        end
    end

endmodule

// File: source/target_buffer.sv
`timescale 1ns/1ps

module target_buffer #(
    parameter int BTB_ENTRIES = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  bpu_pkg::addr_t  lookup_pc_i,
    output logic            btb_hit_o,
    output bpu_pkg::addr_t  btb_target_o,
    bpu_update_if.btb_sink  upd
);

    localparam int IDX_W = (BTB_ENTRIES > 1) ? $clog2(BTB_ENTRIES) : 1;
    localparam int TAG_LSB = bpu_pkg::ADDR_LSB + IDX_W;
    localparam int TAG_W = bpu_pkg::XLEN - TAG_LSB;   // everything above the index

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    logic            valid_q  [BTB_ENTRIES];
    tag_t            tag_q    [BTB_ENTRIES];
    bpu_pkg::addr_t  target_q [BTB_ENTRIES];

    idx_t rd_idx;
    idx_t wr_idx;
    tag_t rd_tag;
    tag_t wr_tag;

    assign rd_idx = lookup_pc_i[bpu_pkg::ADDR_LSB +: IDX_W];
    assign rd_tag = lookup_pc_i[TAG_LSB +: TAG_W];
    assign wr_idx = upd.upd_pc[bpu_pkg::ADDR_LSB +: IDX_W];
    assign wr_tag = upd.upd_pc[TAG_LSB +: TAG_W];

    assign btb_hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign btb_target_o = target_q[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BTB_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (upd.upd_valid && upd.upd_taken) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target only, allocate on taken, not-taken keeps the old entry
    always_ff @(posedge clk) begin
        if (upd.upd_valid && upd.upd_taken) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= upd.upd_target;
        end
    end

endmodule

// File: source/return_stack.sv
`timescale 1ns/1ps

module return_stack #(
    parameter int RAS_DEPTH = 8
) (
    input  logic            clk,
    input  logic            rst,
    output logic            ras_valid_o,
    output bpu_pkg::addr_t  ras_top_o,
    bpu_update_if.ras_sink  upd
);

    localparam int IDX_W = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
    localparam int PTR_W = $clog2(RAS_DEPTH + 1);   // pointer runs 0..RAS_DEPTH

    typedef logic [PTR_W-1:0] ptr_t;

    localparam ptr_t DEPTH_P = ptr_t'(RAS_DEPTH);

    bpu_pkg::addr_t stack_q [RAS_DEPTH];
    ptr_t           ptr_q;      // next free slot
    ptr_t           ptr_pop;
    ptr_t           top_ptr;
    logic           do_pop;
    logic           do_push;

    assign do_pop  = upd.pop_ret && (ptr_q != '0);      // pop on empty ignored
    assign ptr_pop = ptr_q - ptr_t'(do_pop);
    assign do_push = upd.push_valid && (ptr_pop < DEPTH_P);   // full stack drops the push

    assign top_ptr     = (ptr_q == '0) ? '0 : ptr_q - 1'b1;
    assign ras_valid_o = (ptr_q != '0);
    assign ras_top_o   = stack_q[top_ptr[IDX_W-1:0]];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr_q <= '0;
        end else begin
            ptr_q <= ptr_pop + ptr_t'(do_push);
        end
    end

    // pop first, so a same-cycle push lands in the freed slot
    always_ff @(posedge clk) begin
        if (do_push) begin
            stack_q[ptr_pop[IDX_W-1:0]] <= upd.push_addr;
        end
    end

    ptr_in_range: assert property (@(posedge clk) disable iff (rst) ptr_q <= DEPTH_P)
        else $error("ras pointer past depth");

endmodule

// File: source/prediction_select.sv
`timescale 1ns/1ps

module prediction_select (
    input  bpu_pkg::addr_t  if_pc_i,
    input  logic            is_branch_i,
    input  logic            is_jal_i,
    input  logic            is_jalr_i,
    input  logic            is_ret_i,
    input  bpu_pkg::addr_t  static_target_i,
    input  logic            dir_taken_i,
    input  logic            btb_hit_i,
    input  bpu_pkg::addr_t  btb_target_i,
    input  logic            ras_valid_i,
    input  bpu_pkg::addr_t  ras_top_i,
    output logic            is_ctrl_o,
    output logic            pred_taken_o,
    output bpu_pkg::addr_t  pred_pc_o
);

    bpu_pkg::addr_t fall_through;
    bpu_pkg::addr_t direct_target;

    assign fall_through  = if_pc_i + bpu_pkg::addr_t'(4);
    assign direct_target = btb_hit_i ? btb_target_i : static_target_i;  // btb wins over decode
    assign is_ctrl_o     = is_branch_i || is_jal_i || is_jalr_i || is_ret_i;

    always_comb begin
        pred_taken_o = 1'b0;
        pred_pc_o    = fall_through;
        if (is_ret_i) begin
            pred_taken_o = ras_valid_i;   // empty stack falls through
            pred_pc_o    = ras_valid_i ? ras_top_i : fall_through;
        end else if (is_jal_i) begin
            pred_taken_o = 1'b1;
            pred_pc_o    = direct_target;
        end else if (is_branch_i) begin
            pred_taken_o = dir_taken_i;
            pred_pc_o    = dir_taken_i ? direct_target : fall_through;
        end else if (is_jalr_i && dir_taken_i && btb_hit_i) begin
            pred_taken_o = 1'b1;   // no static target for indirect jumps
            pred_pc_o    = btb_target_i;
        end
    end

endmodule

// File: source/bpu_top.sv
`timescale 1ns/1ps

module bpu_top #(
    parameter int DIR_ENTRIES = 64,
    parameter int BTB_ENTRIES = 32,
    parameter int RAS_DEPTH   = 8
) (
    input  logic            clk,
    input  logic            rst,
    input  bpu_pkg::addr_t  if_pc_i,
    input  bpu_pkg::inst_t  if_inst_i,
    input  logic            ex_valid_i,
    input  logic            ex_taken_i,
    input  bpu_pkg::addr_t  ex_pc_i,
    input  bpu_pkg::addr_t  ex_target_i,
    input  bpu_pkg::inst_t  ex_inst_i,
    input  logic            ex_stall_i,
    input  logic            id_push_valid_i,
    input  bpu_pkg::addr_t  id_push_addr_i,
    output logic            is_ctrl_o,
    output logic            pred_taken_o,
    output bpu_pkg::addr_t  pred_pc_o
);

    logic           is_branch, is_jal, is_jalr, is_ret;
    logic           dir_taken, btb_hit, ras_valid;
    bpu_pkg::addr_t static_target, btb_target, ras_top;

    bpu_update_if upd_bus ();

    inst_classifier u_classifier (
        .if_pc_i, .if_inst_i, .ex_valid_i, .ex_taken_i, .ex_stall_i,
        .ex_pc_i, .ex_target_i, .id_push_addr_i, .ex_inst_i, .id_push_valid_i,
        .is_branch_o(is_branch), .is_jal_o(is_jal), .is_jalr_o(is_jalr), .is_ret_o(is_ret),
        .static_target_o(static_target), .upd(upd_bus.source)
    );

    direction_table #(.DIR_ENTRIES(DIR_ENTRIES)) u_dir (
        .clk, .rst, .lookup_pc_i(if_pc_i), .dir_taken_o(dir_taken), .upd(upd_bus.dir_sink)
    );

    target_buffer #(.BTB_ENTRIES(BTB_ENTRIES)) u_btb (
        .clk, .rst, .lookup_pc_i(if_pc_i), .btb_hit_o(btb_hit), .btb_target_o(btb_target),
        .upd(upd_bus.btb_sink)
    );

    return_stack #(.RAS_DEPTH(RAS_DEPTH)) u_ras (
        .clk, .rst, .ras_valid_o(ras_valid), .ras_top_o(ras_top), .upd(upd_bus.ras_sink)
    );

    // final pick, all combinational from the fetch pc and stored state
    prediction_select u_select (
        .if_pc_i, .is_branch_i(is_branch), .is_jal_i(is_jal), .is_jalr_i(is_jalr),
        .is_ret_i(is_ret), .static_target_i(static_target), .dir_taken_i(dir_taken),
        .btb_hit_i(btb_hit), .btb_target_i(btb_target), .ras_valid_i(ras_valid),
        .ras_top_i(ras_top), .is_ctrl_o, .pred_taken_o, .pred_pc_o
    );

endmodule

// File: bench/bpu_tb.sv
`timescale 1ns/1ps

module bpu_tb;

    localparam int DIR_N = 64;
    localparam int BTB_N = 32;
    localparam int RAS_N = 8;
    localparam int TEST_CYCLES = 80;            // reset plus every directed test
    localparam logic [31:0] NOP = 32'h00000013;
    localparam logic [31:0] RET = 32'h00008067; // jalr x0, 0(ra)

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] if_pc_i, if_inst_i, ex_pc_i, ex_target_i, ex_inst_i, id_push_addr_i;
    logic        ex_valid_i, ex_taken_i, ex_stall_i, id_push_valid_i;
    logic        is_ctrl_o, pred_taken_o;
    logic [31:0] pred_pc_o;

    int          errors = 0;
    integer      seed = 32'h1afdf322;

    // reference model state
    int          m_ctr   [DIR_N];   // 0 strong nt .. 3 strong t
    logic        m_valid [BTB_N];
    logic [31:0] m_pc    [BTB_N];
    logic [31:0] m_tgt   [BTB_N];
    logic [31:0] m_stack [$];

    bpu_top #(.DIR_ENTRIES(DIR_N), .BTB_ENTRIES(BTB_N), .RAS_DEPTH(RAS_N)) dut0 (.*);

    always #4 clk = ~clk;

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] enc_branch(input logic [12:0] imm);
        return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
    endfunction

    task automatic idle_inputs();
        if_pc_i = '0;
        if_inst_i = NOP;
        ex_valid_i = 1'b0;
        ex_taken_i = 1'b0;
        ex_pc_i = '0;
        ex_target_i = '0;
        ex_inst_i = NOP;
        ex_stall_i = 1'b0;
        id_push_valid_i = 1'b0;
        id_push_addr_i = '0;
    endtask

    // kind 0 plain, 1 branch, 2 jal, 3 return; stat is pc plus immediate
    task automatic lookup(input logic [31:0] pc, input logic [31:0] inst, input int kind,
                          input logic [31:0] stat);
        int          bi;
        logic        hit;
        logic        exp_taken;
        logic [31:0] exp_pc;
        bi = int'((pc >> 2) % BTB_N);
        hit = m_valid[bi] && (m_pc[bi][31:2] == pc[31:2]);
        exp_taken = 1'b0;
        exp_pc = pc + 32'd4;
        if (kind == 3 && m_stack.size() > 0) begin
            exp_taken = 1'b1;
            exp_pc = m_stack[$];
        end else if (kind == 2 || (kind == 1 && m_ctr[int'((pc >> 2) % DIR_N)] >= 2)) begin
            exp_taken = 1'b1;
            exp_pc = hit ? m_tgt[bi] : stat;
        end
        @(negedge clk);
        idle_inputs();
        if_pc_i = pc;
        if_inst_i = inst;
        #1;
        check_eq("is_ctrl_o", 32'(is_ctrl_o), 32'(kind != 0));
        check_eq("pred_taken_o", 32'(pred_taken_o), 32'(exp_taken));
        check_eq("pred_pc_o", pred_pc_o, exp_pc);
    endtask

    // one cycle of execute feedback and decode push, model follows at the edge
    task automatic drive_cycle(input logic valid, input logic taken, input logic [31:0] pc,
                               input logic [31:0] target, input logic [31:0] inst,
                               input logic stall, input logic push, input logic [31:0] paddr);
        int di;
        int bi;
        di = int'((pc >> 2) % DIR_N);
        bi = int'((pc >> 2) % BTB_N);
        @(negedge clk);
        idle_inputs();
        ex_valid_i = valid;
        ex_taken_i = taken;
        ex_pc_i = pc;
        ex_target_i = target;
        ex_inst_i = inst;
        ex_stall_i = stall;
        id_push_valid_i = push;
        id_push_addr_i = paddr;
        @(posedge clk);
        if (valid) begin
            if (taken && m_ctr[di] < 3)
                m_ctr[di]++;
            else if (!taken && m_ctr[di] > 0)
                m_ctr[di]--;
            if (taken) begin
                m_valid[bi] = 1'b1;
                m_pc[bi] = pc;
                m_tgt[bi] = target;
            end
        end
        if (valid && taken && inst == RET && !stall && m_stack.size() > 0)
            void'(m_stack.pop_back());   // pop before push
        if (push && !stall && m_stack.size() < RAS_N)
            m_stack.push_back(paddr);
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        idle_inputs();
        for (int i = 0; i < DIR_N; i++) m_ctr[i] = 1;
        for (int i = 0; i < BTB_N; i++) m_valid[i] = 1'b0;
        m_stack.delete();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic test_after_reset();
        lookup(32'h0000_0400, NOP, 0, '0);
        lookup(32'h0000_0404, enc_branch(13'd16), 1, 32'h0000_0414);
    endtask

    task automatic test_jal();
        logic [31:0] pc;
        pc = 32'h0000_1000;
        lookup(pc, enc_jal(21'h1fffc0), 2, pc - 32'd64);   // negative offset
        drive_cycle(1'b1, 1'b1, pc, 32'h0000_5550, enc_jal(21'h1fffc0), 1'b0, 1'b0, '0);
        lookup(pc, enc_jal(21'h1fffc0), 2, pc - 32'd64);
    endtask

    task automatic test_counter();
        logic [31:0] pc;
        logic [31:0] pc2;
        pc = ($random(seed) & 32'h00ff_ff00) | 32'h40;      // keeps clear of the jal entry
        pc2 = pc + 32'(DIR_N * 4);                          // same indexes, other tag
        lookup(pc, enc_branch(13'd32), 1, pc + 32'd32);
        drive_cycle(1'b1, 1'b1, pc, 32'h0000_9000, NOP, 1'b0, 1'b0, '0);
        lookup(pc, enc_branch(13'd32), 1, pc + 32'd32);
        repeat (3) drive_cycle(1'b1, 1'b1, pc, 32'h0000_9000, NOP, 1'b0, 1'b0, '0);
        repeat (2) drive_cycle(1'b1, 1'b0, pc, 32'h0000_9000, NOP, 1'b0, 1'b0, '0);
        lookup(pc, enc_branch(13'd32), 1, pc + 32'd32);
        drive_cycle(1'b1, 1'b1, pc, 32'h0000_9000, NOP, 1'b0, 1'b0, '0);
        lookup(pc2, enc_branch(13'h1ff0), 1, pc2 - 32'd16);
    endtask

    task automatic test_returns();
        logic [31:0] rpc;
        logic [31:0] epc;
        rpc = 32'h0000_2010;
        epc = 32'h0000_3008;
        lookup(rpc, RET, 3, '0);
        drive_cycle(1'b0, 1'b0, '0, '0, NOP, 1'b0, 1'b1, 32'h0000_a000);
        drive_cycle(1'b0, 1'b0, '0, '0, NOP, 1'b0, 1'b1, 32'h0000_b000);
        lookup(rpc, RET, 3, '0);
        drive_cycle(1'b1, 1'b1, epc, 32'h0000_b000, RET, 1'b0, 1'b0, '0);
        lookup(rpc, RET, 3, '0);
        drive_cycle(1'b0, 1'b0, '0, '0, NOP, 1'b1, 1'b1, 32'h0000_c000);
        lookup(rpc, RET, 3, '0);
        drive_cycle(1'b1, 1'b1, epc, 32'h0000_a000, RET, 1'b1, 1'b0, '0);
        lookup(rpc, RET, 3, '0);
    endtask

    task automatic test_stack_limits();
        logic [31:0] rpc;
        rpc = 32'h0000_2010;
        for (int i = 0; i < RAS_N + 2; i++) begin
            drive_cycle(1'b0, 1'b0, '0, '0, NOP, 1'b0, 1'b1, 32'h0000_8000 + 32'(i * 16));
            lookup(rpc, RET, 3, '0);
        end
        for (int i = 0; i < RAS_N; i++) begin
            drive_cycle(1'b1, 1'b1, 32'h0000_3008, 32'h0, RET, 1'b0, 1'b0, '0);
            lookup(rpc, RET, 3, '0);
        end
        drive_cycle(1'b0, 1'b0, '0, '0, NOP, 1'b0, 1'b1, 32'h0000_d000);
        drive_cycle(1'b1, 1'b1, 32'h0000_3008, 32'h0, RET, 1'b0, 1'b1, 32'h0000_e000);
        lookup(rpc, RET, 3, '0);
        drive_cycle(1'b1, 1'b1, 32'h0000_3008, 32'h0, RET, 1'b0, 1'b0, '0);
        lookup(rpc, RET, 3, '0);   // one entry only, so empty again
    endtask

    initial begin
        #(TEST_CYCLES * 2 * 8);
        $display("timeout, the directed tests did not finish in time");
        $display("Test failed");
        $finish;
    end

    initial begin
        apply_reset();
        test_after_reset();
        test_jal();
        test_counter();
        test_returns();
        test_stack_limits();
        @(negedge clk);
        idle_inputs();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: bpu.f
source/bpu_pkg.sv
source/bpu_update_if.sv
source/inst_classifier.sv
source/direction_table.sv
source/target_buffer.sv
source/return_stack.sv
source/prediction_select.sv
source/bpu_top.sv
bench/bpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the bpu testbench with verilator, run it and scan the log

verilator --binary --timing -Wno-fatal --top-module bpu_tb -f bpu.f -o bpu_sim \
    && ./obj_dir/bpu_sim > sim.log 2>&1 \
    || { echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
